//--- Bender.yml
package:
  name: tile_video

sources:
  # Design, in compile order
  - files:
      - logic/tile_video_pkg.sv
      - logic/video_beam.sv
      - logic/vram_bus_decode.sv
      - logic/tile_fetch.sv
      - logic/pixel_shift.sv
      - logic/tile_video_top.sv

  # Simulation only
  - target: test
    files:
      - test/tile_video_assertions.sv
      - test/tb_tile_video.sv

//--- logic/pixel_shift.sv
/* Pixel shifter. Holds the next tile until its column starts, then shifts
   both planes out one bit per active slot and tags each pixel with x and y. */
`timescale 1ns/1ns
`default_nettype none

module pixel_shift (
	input  logic                   CLK_24M,
	input  logic                   I_H_CNT,
	input  tile_video_pkg::beam_t  beam,
	input  logic                   flip,
	input  tile_video_pkg::tile_t  tile,
	output tile_video_pkg::pixel_t pix
);
	import tile_video_pkg::*;

	// Pending tile waits for its column
	logic [7:0] pend_x;
	logic [7:0] pend_y;
	logic [7:0] pend_p0;
	logic [7:0] pend_p1;
	logic [3:0] pend_col;
	// Tile being shifted out
	logic [7:0] sh_p0;
	logic [7:0] sh_p1;
	logic [7:0] cur_y;
	logic [3:0] cur_col;
	logic       shift_en;
	logic       swap;
	logic [7:0] src_p0;
	logic [7:0] src_p1;
	logic [7:0] src_y;
	logic [3:0] src_col;
	logic       pix_valid;
	logic [7:0] pix_x;
	logic [7:0] pix_y;
	logic [1:0] pix_vid;
	logic [3:0] pix_col;

	assign shift_en = beam.pix_en && beam.active;
	assign swap     = shift_en && (beam.h == {1'b0, pend_x});

	// First pixel of a column comes straight from the pending tile
	always_comb begin
		src_p0  = swap ? pend_p0 : sh_p0;
		src_p1  = swap ? pend_p1 : sh_p1;
		src_y   = swap ? pend_y : cur_y;
		src_col = swap ? pend_col : cur_col;
	end

	// ------------------------------------------------------------
	// Tile buffers and shifters
	// ------------------------------------------------------------
	always_ff @(posedge CLK_24M) begin
		if (tile.load) begin
			pend_x   <= tile.x_base;
			pend_y   <= tile.y;
			pend_p0  <= tile.plane0;
			pend_p1  <= tile.plane1;
			pend_col <= tile.color;
		end
		if (shift_en) begin
			// Flip takes bit 0 first
			sh_p0   <= flip ? src_p0 >> 1 : src_p0 << 1;
			sh_p1   <= flip ? src_p1 >> 1 : src_p1 << 1;
			cur_y   <= src_y;
			cur_col <= src_col;
			pix_x   <= beam.h[7:0];
			pix_y   <= src_y;
			// plane1 is the high bit
			pix_vid <= flip ? {src_p1[0], src_p0[0]} : {src_p1[7], src_p0[7]};
			pix_col <= src_col;
		end
	end

	always_ff @(posedge CLK_24M or negedge I_H_CNT) begin
		if (!I_H_CNT)
			pix_valid <= 1'b0;
		else
			pix_valid <= shift_en;
	end

	assign pix = '{valid: pix_valid, x: pix_x, y: pix_y, vid: pix_vid, col: pix_col};

endmodule

`default_nettype wire

//--- logic/tile_fetch.sv
/* Tile memories and the per-tile fetch. During busy it reads code, pattern
   bytes and colour for the next column and hands the tile to the shifter. */
`timescale 1ns/1ns
`default_nettype none

module tile_fetch #(
	parameter int PIX_DIV = 4
) (
	input  logic                    CLK_24M,
	input  logic                    I_H_CNT,
	input  tile_video_pkg::beam_t   beam,
	input  logic                    flip,
	input  tile_video_pkg::mem_wr_t mem_wr,
	input  logic                    code_rd,
	output logic [7:0]              cpu_rdata,
	output tile_video_pkg::tile_t   tile
);
	import tile_video_pkg::*;

	// Whole sequence fits inside one slot
	localparam int SEQ_W = $clog2(PIX_DIV);
	localparam logic [SEQ_W-1:0] SEQ_IDLE = SEQ_W'(0);
	localparam logic [SEQ_W-1:0] SEQ_GFX  = SEQ_W'(1);
	localparam logic [SEQ_W-1:0] SEQ_LOAD = SEQ_W'(2);

	logic [7:0]       code_mem [1024];
	logic [3:0]       color_mem [256];
	logic [7:0]       code_q;
	logic [3:0]       color_q;
	logic [SEQ_W-1:0] seq;
	logic             start;
	logic             gfx_rd;
	logic [8:0]       tgt_h;
	logic [8:0]       nxt_line;
	logic [7:0]       fy;
	logic [4:0]       fcol;
	logic [9:0]       code_addr;
	logic [10:0]      gfx_addr;
	// Tile under fetch
	logic [7:0]       x_base_q;
	logic [7:0]       y_q;
	logic [7:0]       col_addr_q;

	// ------------------------------------------------------------
	// Target column and flipped tile index
	// ------------------------------------------------------------
	always_comb begin
		// Next column start, lead-in wraps into column 0
		tgt_h = (beam.h >= 9'(H_TOTAL - 8)) ? beam.h - 9'(H_TOTAL - 8) : beam.h + 9'd8;
		nxt_line = (beam.v == 9'(V_TOTAL - 1)) ? 9'd0 : beam.v + 9'd1;
		fy = (beam.h >= 9'(H_ACTIVE)) ? nxt_line[7:0] : beam.v[7:0];
		// 255-x on the column bits
		fcol = flip ? ~tgt_h[7:3] : tgt_h[7:3];
		start = beam.pix_en && beam.busy && (beam.h[2:0] == 3'd0) &&
			(tgt_h < 9'(H_ACTIVE));
		// Fetch and CPU never share a clock on this port
		code_addr = start ? {fy[7:3], fcol} : mem_wr.addr[9:0];
	end

	assign gfx_rd   = (seq == SEQ_GFX);
	assign gfx_addr = {code_q, y_q[2:0]};

	// Tile-code RAM with the shared port
	always_ff @(posedge CLK_24M) begin
		if (mem_wr.sel == CODE)
			code_mem[code_addr] <= mem_wr.data;
		if (start || code_rd)
			code_q <= code_mem[code_addr];
	end

	// Pattern planes, one RAM each
	for (genvar p = 0; p < 2; p++) begin : g_plane
		localparam region_e SEL = region_e'((p == 0) ? PLANE0 : PLANE1);
		logic [7:0] mem [2048];
		logic [7:0] rd_q;
		always_ff @(posedge CLK_24M) begin
			if (mem_wr.sel == SEL)
				mem[mem_wr.addr[10:0]] <= mem_wr.data;
			if (gfx_rd)
				rd_q <= mem[gfx_addr];
		end
	end

	// Colour table, low nibble only
	always_ff @(posedge CLK_24M) begin
		if (mem_wr.sel == COLOR)
			color_mem[mem_wr.addr[7:0]] <= mem_wr.data[3:0];
		if (gfx_rd)
			color_q <= color_mem[col_addr_q];
	end

	// Code read, then gfx read, then load
	always_ff @(posedge CLK_24M or negedge I_H_CNT) begin
		if (!I_H_CNT)
			seq <= SEQ_IDLE;
		else if (start)
			seq <= SEQ_GFX;
		else if (seq == SEQ_GFX)
			seq <= SEQ_LOAD;
		else
			seq <= SEQ_IDLE;
	end

	always_ff @(posedge CLK_24M) begin
		if (start) begin
			x_base_q   <= tgt_h[7:0];
			y_q        <= fy;
			col_addr_q <= {fy[7:5], fcol};
		end
	end

	assign cpu_rdata = code_q;
	assign tile = '{x_base: x_base_q, y: y_q, plane0: g_plane[0].rd_q,
		plane1: g_plane[1].rd_q, color: color_q, load: (seq == SEQ_LOAD)};

endmodule

`default_nettype wire

//--- logic/tile_video_pkg.sv
/* Raster constants, bus records and stage records shared by the tile video layer.
   Every block imports this package inside its body. */
`default_nettype none

package tile_video_pkg;

	// ------------------------------------------------------------
	// Raster geometry in pixel slots and lines
	// ------------------------------------------------------------
	localparam int H_TOTAL    = 384;
	localparam int H_ACTIVE   = 256;
	localparam int V_TOTAL    = 264;
	localparam int V_ACTIVE   = 224;
	// Busy rises this many slots before line start
	localparam int FETCH_LEAD = 16;

	// Beam position and per-slot flags
	typedef struct packed {
		logic [8:0] h;
		logic [8:0] v;
		logic       pix_en;
		logic       active;
		logic       busy;
	} beam_t;

	// Wishbone classic request and response
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [15:0] adr;
		logic [7:0]  dat;
	} wb_req_t;

	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_rsp_t;

	// Loader address seen as a gfx bank or as a colour page
	typedef union packed {
		struct packed {
			logic [3:0]  bank;
			logic [11:0] offset;
		} gfx;
		struct packed {
			logic [7:0] page;
			logic [7:0] index;
		} col;
	} dl_addr_u;

	typedef enum logic [2:0] {NONE, CODE, PLANE0, PLANE1, COLOR} region_e;

	// Write command from bus decode to the memories
	typedef struct packed {
		region_e     sel;
		logic [11:0] addr;
		logic [7:0]  data;
	} mem_wr_t;

	// One fetched tile on its way to the shifters
	typedef struct packed {
		logic [7:0] x_base;
		logic [7:0] y;
		logic [7:0] plane0;
		logic [7:0] plane1;
		logic [3:0] color;
		logic       load;
	} tile_t;

	// Pixel with its screen position tags
	typedef struct packed {
		logic       valid;
		logic [7:0] x;
		logic [7:0] y;
		logic [1:0] vid;
		logic [3:0] col;
	} pixel_t;

endpackage

`default_nettype wire

//--- logic/tile_video_top.sv
/* Tile layer top level. Sets the pixel divider and connects beam,
   bus decode, tile fetch and pixel shift. */
`timescale 1ns/1ns
`default_nettype none

module tile_video_top #(
	parameter int PIX_DIV = 4
) (
	input  logic                    CLK_24M,
	input  logic                    I_H_CNT,
	input  tile_video_pkg::wb_req_t bus_req,
	output tile_video_pkg::wb_rsp_t bus_rsp,
	input  logic                    flip,
	output tile_video_pkg::pixel_t  pix
);
	import tile_video_pkg::*;

	// ------------------------------------------------------------
	// Internal links
	// ------------------------------------------------------------
	beam_t      beam;
	mem_wr_t    mem_wr;
	logic       code_rd;
	logic [7:0] cpu_rdata;
	tile_t      tile;

	// Raster timing for all blocks
	video_beam #(.PIX_DIV(PIX_DIV)) u_beam (
		.CLK_24M (CLK_24M),
		.I_H_CNT (I_H_CNT),
		.beam    (beam)
	);

	// CPU and loader port
	vram_bus_decode u_decode (
		.CLK_24M   (CLK_24M),
		.I_H_CNT   (I_H_CNT),
		.bus_req   (bus_req),
		.bus_rsp   (bus_rsp),
		.beam      (beam),
		.mem_wr    (mem_wr),
		.code_rd   (code_rd),
		.cpu_rdata (cpu_rdata)
	);

	tile_fetch #(.PIX_DIV(PIX_DIV)) u_fetch (
		.CLK_24M   (CLK_24M),
		.I_H_CNT   (I_H_CNT),
		.beam      (beam),
		.flip      (flip),
		.mem_wr    (mem_wr),
		.code_rd   (code_rd),
		.cpu_rdata (cpu_rdata),
		.tile      (tile)
	);

	pixel_shift u_shift (
		.CLK_24M (CLK_24M),
		.I_H_CNT (I_H_CNT),
		.beam    (beam),
		.flip    (flip),
		.tile    (tile),
		.pix     (pix)
	);

endmodule

`default_nettype wire

//--- logic/video_beam.sv
/* Beam generator. Walks the raster one slot every PIX_DIV clocks and
   flags the visible area and the tile-fetch window for all other blocks. */
`timescale 1ns/1ns
`default_nettype none

module video_beam #(
	parameter int PIX_DIV = 4
) (
	input  logic                  CLK_24M,
	input  logic                  I_H_CNT,
	output tile_video_pkg::beam_t beam
);
	import tile_video_pkg::*;

	localparam int DIV_W = $clog2(PIX_DIV);

	logic [DIV_W-1:0] div_cnt;
	logic             slot_end;
	logic             pix_en;
	logic [8:0]       h_cnt;
	logic [8:0]       v_cnt;
	logic [8:0]       h_nxt;
	logic [8:0]       v_nxt;
	// Line after v_nxt, served by the lead-in fetches
	logic [8:0]       v_fol;
	logic             active;
	logic             busy;
	logic             lead_busy;
	logic             disp_busy;

	// Last clock of the current slot
	assign slot_end = (div_cnt == DIV_W'(PIX_DIV - 1));

	// ------------------------------------------------------------
	// Next beam position and the flags that go with it
	// ------------------------------------------------------------
	always_comb begin
		h_nxt = (h_cnt == 9'(H_TOTAL - 1)) ? 9'd0 : h_cnt + 9'd1;
		v_nxt = v_cnt;
		// Vertical step on horizontal wrap
		if (h_cnt == 9'(H_TOTAL - 1))
			v_nxt = (v_cnt == 9'(V_TOTAL - 1)) ? 9'd0 : v_cnt + 9'd1;
		v_fol = (v_nxt == 9'(V_TOTAL - 1)) ? 9'd0 : v_nxt + 9'd1;
		// Lead-in belongs to the line that follows
		lead_busy = (h_nxt >= 9'(H_TOTAL - FETCH_LEAD)) && (v_fol < 9'(V_ACTIVE));
		disp_busy = (h_nxt < 9'(H_ACTIVE)) && (v_nxt < 9'(V_ACTIVE));
	end

	// Position and flags all change on the same clock
	always_ff @(posedge CLK_24M or negedge I_H_CNT) begin
		if (!I_H_CNT) begin
			div_cnt <= '0;
			pix_en  <= 1'b0;
			h_cnt   <= 9'd0;
			v_cnt   <= 9'(V_TOTAL - 1);
			active  <= 1'b0;
			busy    <= 1'b0;
		end else begin
			pix_en <= slot_end;
			if (slot_end) begin
				div_cnt <= '0;
				h_cnt   <= h_nxt;
				v_cnt   <= v_nxt;
				active  <= (h_nxt < 9'(H_ACTIVE)) && (v_nxt < 9'(V_ACTIVE));
				busy    <= lead_busy || disp_busy;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// pix_en marks the first clock of each slot
	assign beam = '{h: h_cnt, v: v_cnt, pix_en: pix_en, active: active, busy: busy};

endmodule

`default_nettype wire

//--- logic/vram_bus_decode.sv
/* Wishbone classic slave for the CPU and the loader. Decodes the region,
   holds tile-code accesses off while the beam fetches, and returns ack. */
`timescale 1ns/1ns
`default_nettype none

module vram_bus_decode (
	input  logic                    CLK_24M,
	input  logic                    I_H_CNT,
	input  tile_video_pkg::wb_req_t bus_req,
	output tile_video_pkg::wb_rsp_t bus_rsp,
	input  tile_video_pkg::beam_t   beam,
	output tile_video_pkg::mem_wr_t mem_wr,
	output logic                    code_rd,
	input  logic [7:0]              cpu_rdata
);
	import tile_video_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_ACCESS, ST_ACK} state_e;

	state_e      state;
	dl_addr_u    adr_u;
	region_e     region;
	logic [11:0] rgn_addr;
	logic        req;
	logic        ack;
	// Registered write command
	region_e     mem_sel;
	logic [11:0] mem_addr;
	logic [7:0]  mem_data;
	// Current access returns tile-code data
	logic        rd_code;

	assign adr_u = bus_req.adr;
	assign req   = bus_req.cyc && bus_req.stb;

	// ------------------------------------------------------------
	// Region decode through both address views
	// ------------------------------------------------------------
	always_comb begin
		region   = NONE;
		rgn_addr = 12'h000;
		if (adr_u.col.page < 8'h04) begin
			region   = CODE;
			rgn_addr = {2'b00, adr_u.col.page[1:0], adr_u.col.index};
		end else if (adr_u.gfx.bank == 4'h8 && !adr_u.gfx.offset[11]) begin
			region   = PLANE0;
			rgn_addr = adr_u.gfx.offset;
		end else if (adr_u.gfx.bank == 4'h9 && !adr_u.gfx.offset[11]) begin
			region   = PLANE1;
			rgn_addr = adr_u.gfx.offset;
		end else if (adr_u.col.page == 8'hF4) begin
			region   = COLOR;
			rgn_addr = {4'h0, adr_u.col.index};
		end
	end

	// Access FSM
	always_ff @(posedge CLK_24M or negedge I_H_CNT) begin
		if (!I_H_CNT) begin
			state   <= ST_IDLE;
			mem_sel <= NONE;
			code_rd <= 1'b0;
			rd_code <= 1'b0;
		end else begin
			// Commands last one clock
			mem_sel <= NONE;
			code_rd <= 1'b0;
			case (state)
				ST_IDLE, ST_WAIT: begin
					if (!req) begin
						state <= ST_IDLE;
					end else if (region != CODE) begin
						// Unmapped writes carry NONE and are dropped
						if (bus_req.we)
							mem_sel <= region;
						rd_code <= 1'b0;
						state   <= ST_ACK;
					end else if (!beam.busy) begin
						if (bus_req.we)
							mem_sel <= CODE;
						else
							code_rd <= 1'b1;
						rd_code <= !bus_req.we;
						state   <= ST_ACCESS;
					end else begin
						state <= ST_WAIT;
					end
				end
				// RAM works on the command here
				ST_ACCESS: state <= ST_ACK;
				default:   state <= ST_IDLE;
			endcase
		end
	end

	// Address and data follow the held request
	always_ff @(posedge CLK_24M) begin
		if (state == ST_IDLE || state == ST_WAIT) begin
			mem_addr <= rgn_addr;
			mem_data <= bus_req.dat;
		end
	end

	assign mem_wr  = '{sel: mem_sel, addr: mem_addr, data: mem_data};
	assign ack     = (state == ST_ACK);
	// Only tile-code reads return data
	assign bus_rsp = '{ack: ack, dat: (ack && rd_code) ? cpu_rdata : 8'h00};

endmodule

`default_nettype wire

//--- tb.f
logic/tile_video_pkg.sv
logic/video_beam.sv
logic/vram_bus_decode.sv
logic/tile_fetch.sv
logic/pixel_shift.sv
logic/tile_video_top.sv
test/tile_video_assertions.sv
test/tb_tile_video.sv

//--- test/tb_tile_video.sv
/* Testbench for the tile video layer. Loads the memories over the bus, runs
   directed tests and compares pixels with a model of the tile rules. */
`timescale 1ns/1ns
`default_nettype none

module tb_tile_video;
	import tile_video_pkg::*;

	localparam int BUS_TIMEOUT = 5000;
	// A little more than one frame of clocks
	localparam int PIX_TIMEOUT = 500000;

	logic    CLK_24M = 1'b0;
	logic    I_H_CNT;
	wb_req_t bus_req;
	wb_rsp_t bus_rsp;
	logic    flip;
	pixel_t  pix;

	// Model memories, written alongside the DUT
	logic [7:0] code_m [1024];
	logic [7:0] p0_m [2048];
	logic [7:0] p1_m [2048];
	logic [3:0] col_m [256];

	tile_video_top #(.PIX_DIV(4)) dut0 (
		.CLK_24M (CLK_24M),
		.I_H_CNT (I_H_CNT),
		.bus_req (bus_req),
		.bus_rsp (bus_rsp),
		.flip    (flip),
		.pix     (pix)
	);

	always #2 CLK_24M = ~CLK_24M;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "Run stopped on first failure");
	endtask

	// ------------------------------------------------------------
	// Bus and beam helpers
	// ------------------------------------------------------------
	task automatic bus_cycle(input logic we, input logic [15:0] adr, input logic [7:0] dat,
		output wb_rsp_t rsp);
		int n;
		n = 0;
		@(posedge CLK_24M);
		bus_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
		// Request held steady until ack
		do begin
			@(posedge CLK_24M);
			n++;
			if (n > BUS_TIMEOUT)
				stop_run($sformatf("Timed out waiting for bus ack at address %h", adr));
		end while (!bus_rsp.ack);
		rsp = bus_rsp;
		bus_req <= '0;
	endtask

	task automatic wb_write(input logic [15:0] adr, input logic [7:0] dat);
		wb_rsp_t rsp;
		bus_cycle(1'b1, adr, dat, rsp);
	endtask

	task automatic wb_read(input logic [15:0] adr, output wb_rsp_t rsp);
		bus_cycle(1'b0, adr, 8'h00, rsp);
	endtask

	// Waits until the beam is inside a fetch window
	task automatic wait_busy();
		int n;
		n = 0;
		while (!dut0.beam.busy) begin
			@(posedge CLK_24M);
			n++;
			if (n > PIX_TIMEOUT)
				stop_run("Timed out waiting for the beam fetch window");
		end
	endtask

	task automatic wait_pixel(input logic [7:0] x, input logic [7:0] y, output pixel_t got);
		int n;
		n = 0;
		do begin
			@(posedge CLK_24M);
			n++;
			if (n > PIX_TIMEOUT)
				stop_run($sformatf("Timed out waiting for pixel x=%0d y=%0d", x, y));
		end while (!(pix.valid && pix.x == x && pix.y == y));
		got = pix;
	endtask

	// ------------------------------------------------------------
	// Checks and the pixel model
	// ------------------------------------------------------------
	task automatic check_rsp(input wb_rsp_t got, input wb_rsp_t exp, input string what);
		if (got !== exp)
			stop_run($sformatf("Error at %0t: %s gave ack=%b dat=%h, expected ack=%b dat=%h",
				$time, what, got.ack, got.dat, exp.ack, exp.dat));
	endtask

	task automatic check_pixel(input pixel_t got, input pixel_t exp);
		if (got !== exp)
			stop_run($sformatf("Error at %0t: pixel x=%0d y=%0d gave vid=%0d col=%h, %s%0d col=%h",
				$time, exp.x, exp.y, got.vid, got.col, "expected vid=", exp.vid, exp.col));
	endtask

	function automatic pixel_t expected_pixel(input logic [7:0] x, input logic [7:0] y,
		input logic fl);
		logic [7:0]  fx;
		logic [9:0]  idx;
		logic [10:0] gadr;
		logic [2:0]  bitn;
		pixel_t      p;
		// Flip mirrors the column
		fx   = fl ? 8'd255 - x : x;
		idx  = 10'((y / 8) * 32 + fx / 8);
		gadr = 11'(code_m[idx] * 8 + y % 8);
		bitn = 3'(7 - fx % 8);
		p.valid = 1'b1;
		p.x     = x;
		p.y     = y;
		p.vid   = {p1_m[gadr][bitn], p0_m[gadr][bitn]};
		p.col   = col_m[8'((y / 32) * 32 + fx / 8)];
		return p;
	endfunction

	// Every pixel of one line against the model
	task automatic scan_line(input logic [7:0] y);
		pixel_t got;
		for (int x = 0; x < H_ACTIVE; x++) begin
			wait_pixel(8'(x), y, got);
			check_pixel(got, expected_pixel(8'(x), y, flip));
		end
	endtask

	// ------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------
	task automatic code_ram_round_trip();
		logic [9:0] adr [32];
		logic [7:0] dat;
		wb_rsp_t    rsp;
		for (int i = 0; i < 32; i++) begin
			adr[i] = 10'($urandom);
			dat    = 8'($urandom);
			// Issued inside the fetch window so the hold-off is exercised
			wait_busy();
			wb_write({6'd0, adr[i]}, dat);
			code_m[adr[i]] = dat;
		end
		for (int i = 0; i < 32; i++) begin
			wait_busy();
			wb_read({6'd0, adr[i]}, rsp);
			check_rsp(rsp, wb_rsp_t'{ack: 1'b1, dat: code_m[adr[i]]}, "Tile-code read");
		end
	endtask

	task automatic unmapped_regions();
		wb_rsp_t rsp;
		wb_read(16'h8000, rsp);
		check_rsp(rsp, wb_rsp_t'{ack: 1'b1, dat: 8'h00}, "Pattern read");
		wb_read(16'hF400, rsp);
		check_rsp(rsp, wb_rsp_t'{ack: 1'b1, dat: 8'h00}, "Colour read");
		wb_read(16'h5000, rsp);
		check_rsp(rsp, wb_rsp_t'{ack: 1'b1, dat: 8'h00}, "Unmapped read");
		// Low bits of 0x5000 match code byte 0
		wb_write(16'h0000, 8'h3C);
		code_m[0] = 8'h3C;
		wb_write(16'h5000, 8'hC3);
		wb_read(16'h0000, rsp);
		check_rsp(rsp, wb_rsp_t'{ack: 1'b1, dat: 8'h3C}, "Code byte after unmapped write");
	endtask

	task automatic load_tile_data();
		logic [7:0] dat;
		for (int i = 0; i < 2048; i++) begin
			dat = 8'($urandom);
			wb_write(16'h8000 + 16'(i), dat);
			p0_m[i] = dat;
			dat = 8'($urandom);
			wb_write(16'h9000 + 16'(i), dat);
			p1_m[i] = dat;
		end
		for (int i = 0; i < 256; i++) begin
			dat = 8'($urandom);
			wb_write(16'hF400 + 16'(i), dat);
			col_m[i] = dat[3:0];
		end
		for (int i = 0; i < 1024; i++) begin
			dat = 8'($urandom);
			wb_write(16'(i), dat);
			code_m[i] = dat;
		end
	endtask

	task automatic unflipped_pixels();
		scan_line(8'd41);
		scan_line(8'd46);
	endtask

	task automatic flipped_pixels();
		pixel_t got;
		// Last visible pixel, so flip changes in vertical blank
		wait_pixel(8'd255, 8'(V_ACTIVE - 1), got);
		flip <= 1'b1;
		scan_line(8'd97);
		scan_line(8'd102);
	endtask

	task automatic display_write();
		pixel_t     got;
		logic [9:0] idx;
		logic [7:0] dat;
		wait_pixel(8'd0, 8'd100, got);
		// Tile at screen column 10 of tile row 20
		idx = 10'(20 * 32 + (flip ? 31 - 10 : 10));
		dat = code_m[idx] ^ 8'hA5;
		wb_write({6'd0, idx}, dat);
		code_m[idx] = dat;
		wait_pixel(8'd255, 8'(V_ACTIVE - 1), got);
		scan_line(8'd160);
		scan_line(8'd167);
	endtask

	initial begin
		void'($urandom(25));
		I_H_CNT = 1'b0;
		bus_req = '0;
		flip    = 1'b0;
		repeat (4) @(posedge CLK_24M);
		I_H_CNT <= 1'b1;
		code_ram_round_trip();
		unmapped_regions();
		load_tile_data();
		unflipped_pixels();
		flipped_pixels();
		display_write();
		if (dut0.u_decode.bus_chk.err_cnt + dut0.u_shift.pix_chk.err_cnt != 0) begin
			$display("Bound assertions failed during the run");
			$display("** FAIL **");
			$fatal(1, "Run stopped on assertion failures");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- test/tile_video_assertions.sv
/* Concurrent checks on the bus and pixel protocol. Bound into the bus
   decoder and the pixel shifter, with the side each lacks tied off. */
`timescale 1ns/1ns
`default_nettype none

module tile_video_assertions (
	input logic                    CLK_24M,
	input logic                    I_H_CNT,
	input tile_video_pkg::wb_req_t bus_req,
	input tile_video_pkg::wb_rsp_t bus_rsp,
	input tile_video_pkg::beam_t   beam,
	input tile_video_pkg::pixel_t  pix
);
	import tile_video_pkg::*;

	int   err_cnt = 0;
	logic req;
	logic code_req;

	assign req      = bus_req.cyc && bus_req.stb;
	assign code_req = req && (bus_req.adr < 16'h0400);

	// Ack belongs to a live cycle
	a_ack_in_cycle: assert property (@(posedge CLK_24M) disable iff (!I_H_CNT)
		bus_rsp.ack |-> req)
	else begin
		err_cnt++;
		$error("ack without cyc and stb");
	end

	// Held-off tile-code access never acks at once
	a_code_hold: assert property (@(posedge CLK_24M) disable iff (!I_H_CNT)
		$rose(code_req) && beam.busy |=> !bus_rsp.ack)
	else begin
		err_cnt++;
		$error("tile-code ack on the clock after a request during busy");
	end

	a_pix_area: assert property (@(posedge CLK_24M) disable iff (!I_H_CNT)
		pix.valid |-> (pix.x < H_ACTIVE) && (pix.y < V_ACTIVE))
	else begin
		err_cnt++;
		$error("pixel tagged outside the visible area");
	end

endmodule

// Bus side
bind vram_bus_decode tile_video_assertions bus_chk (
	.CLK_24M (CLK_24M),
	.I_H_CNT (I_H_CNT),
	.bus_req (bus_req),
	.bus_rsp (bus_rsp),
	.beam    (beam),
	.pix     ('0)
);

// Pixel side
bind pixel_shift tile_video_assertions pix_chk (
	.CLK_24M (CLK_24M),
	.I_H_CNT (I_H_CNT),
	.bus_req ('0),
	.bus_rsp ('0),
	.beam    (beam),
	.pix     (pix)
);

`default_nettype wire
